/* Bender.yml */
package:
  name: fetch_stage

sources:
  - common/fetch_pkg.sv
  - common/icache_if.sv
  - fetch/fetch_control.sv
  - fetch/fetch_line_buffer.sv
  - fetch/fetch_aligner.sv
  - hw/fetch_top.sv
  - target: test
    files:
      - verification/clock_gen.sv
      - verification/fetch_tb.sv

/* common/fetch_pkg.sv */
// fetch package with the widths, redirect source encoding and read pointer layout of the fetch stage
`default_nettype none

package fetch_pkg;

  // bytes per cache line and depth of the line ring
  localparam int LINE_BYTES = 16;
  localparam int NUM_LINES  = 4;

  // linear instruction address
  typedef logic [31:0] addr_t;

  // one cache line with byte 0 in the lowest bits
  typedef logic [LINE_BYTES*8-1:0] line_t;

  // source of the value loaded on a redirect
  typedef enum logic [1:0] {
    sel_eip  = 2'b00,
    sel_jump = 2'b01,
    sel_trap = 2'b10
  } sel_t;

  // read pointer into the ring with the slot above the byte offset
  typedef struct packed {
    logic [$clog2(NUM_LINES)-1:0]  slot;
    logic [$clog2(LINE_BYTES)-1:0] offset;
  } ptr_t;

  // bytes taken by one decoded instruction (1 to 15)
  typedef logic [3:0] len_t;

endpackage

`default_nettype wire

/* common/icache_if.sv */
// instruction cache port carrying the request handshake and line response of the fetch blocks
`timescale 1ns/1ps
`default_nettype none

interface icache_if
  import fetch_pkg::*;
();

  // request side with a line aligned address held until accepted
  logic  req_valid;
  logic  req_ready;
  addr_t req_addr;

  // response side as a single cycle pulse carrying the whole line
  logic  rsp_valid;
  line_t rsp_data;

  modport requester (
    output req_valid,
    output req_addr,
    input  req_ready,
    input  rsp_valid
  );

  modport filler (
    input rsp_data
  );

endinterface

`default_nettype wire

/* fetch/fetch_aligner.sv */
// fetch aligner that rotates two lines to cut out the 16-byte instruction window
`timescale 1ns/1ps
`default_nettype none

module fetch_aligner
  import fetch_pkg::*;
(
  input  wire line_t      line_lo,
  input  wire line_t      line_hi,
  input  wire logic [3:0] offset,
  output line_t           ir
);

  logic [7:0] pair_bytes [2*LINE_BYTES];

  // lower line supplies bytes 0..15 and the following line 16..31
  always_comb
  begin
    for (int i = 0; i < LINE_BYTES; i++)
    begin
      pair_bytes[i]              = line_lo[i*8 +: 8];
      pair_bytes[i + LINE_BYTES] = line_hi[i*8 +: 8];
    end
  end

  // byte i of the window comes from byte offset+i of the pair
  always_comb
  begin
    for (int i = 0; i < LINE_BYTES; i++)
    begin
      ir[i*8 +: 8] = pair_bytes[i + int'(offset)];
    end
  end

endmodule

`default_nettype wire

/* fetch/fetch_control.sv */
// fetch control block for the instruction pointer, redirects, cache requests and segment limit check
`timescale 1ns/1ps
`default_nettype none

module fetch_control
  import fetch_pkg::*;
#(
  parameter logic [15:0] RESET_CS = 16'hf000
) (
  input  wire logic       clk,
  input  wire logic       reset,
  input  wire logic       load_eip,
  input  wire sel_t       redirect_sel,
  input  wire addr_t      eip,
  input  wire addr_t      jmp_target,
  input  wire addr_t      trap_target,
  input  wire logic [15:0] cs_in,
  input  wire addr_t      cs_limit,
  input  wire logic       line_free,
  input  wire logic       consume,
  input  wire len_t       ir_len,
  output logic            line_write,
  output logic            flush,
  output logic [3:0]      start_offset,
  output addr_t           ir_eip,
  output logic [15:0]     ir_cs,
  output logic            segment_limit_exception,
  icache_if.requester     cache
);

  addr_t target;
  addr_t target_line;
  addr_t eip_next;
  addr_t fetch_addr;
  logic  active;
  logic  outstanding;
  logic  stale;
  logic  req_valid_q;
  logic  accepted;
  logic  busy_after_redirect;
  logic  issue;
  logic  exc_next;

  // true when a 16-byte window starting at start runs past the limit
  function automatic logic past_limit(input addr_t start, input addr_t limit);
    logic [32:0] window_end;
    window_end = {1'b0, start} + 33'd15;
    return window_end > {1'b0, limit};
  endfunction

  always_comb
  begin
    case (redirect_sel)
      sel_jump: target = jmp_target;
      sel_trap: target = trap_target;
      default:  target = eip;
    endcase
  end

  assign target_line  = {target[31:4], 4'h0};
  assign start_offset = target[3:0];
  assign flush        = load_eip;

  assign accepted = req_valid_q & cache.req_ready;

  // a request still in flight across a redirect must be answered and dropped
  assign busy_after_redirect = (outstanding & ~cache.rsp_valid) | accepted;

  // only one request at a time and never for a line past the segment limit
  assign issue = active & ~segment_limit_exception & ~req_valid_q & ~outstanding
               & line_free & (fetch_addr <= cs_limit);

  assign line_write = cache.rsp_valid & outstanding & ~stale & ~load_eip;

  assign cache.req_valid = req_valid_q;
  assign cache.req_addr  = fetch_addr;

  // redirect wins over a consumption in the same cycle
  always_comb
  begin
    if (load_eip)
      eip_next = target;
    else if (consume)
      eip_next = ir_eip + addr_t'(ir_len);
    else
      eip_next = ir_eip;
  end

  // checked on the next pointer so the window is blocked before it is offered
  assign exc_next = load_eip ? past_limit(eip_next, cs_limit)
                             : segment_limit_exception | (active & past_limit(eip_next, cs_limit));

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      active                  <= 1'b0;
      outstanding             <= 1'b0;
      stale                   <= 1'b0;
      req_valid_q             <= 1'b0;
      segment_limit_exception <= 1'b0;
      ir_eip                  <= '0;
      ir_cs                   <= RESET_CS;
    end
    else
    begin
      segment_limit_exception <= exc_next;
      ir_eip                  <= eip_next;
      if (load_eip)
      begin
        active      <= 1'b1;
        ir_cs       <= cs_in;
        outstanding <= busy_after_redirect;
        stale       <= busy_after_redirect;
        // first line of the new target goes out right away unless a request is pending
        req_valid_q <= ~busy_after_redirect & (target_line <= cs_limit);
      end
      else
      begin
        if (accepted)
        begin
          req_valid_q <= 1'b0;
          outstanding <= 1'b1;
        end
        else if (issue)
          req_valid_q <= 1'b1;

        if (outstanding & cache.rsp_valid)
        begin
          outstanding <= 1'b0;
          stale       <= 1'b0;
        end
      end
    end
  end

  // next line address to fetch is advanced as each request is taken
  always_ff @(posedge clk)
  begin
    if (load_eip)
      fetch_addr <= target_line;
    else if (accepted)
      fetch_addr <= fetch_addr + addr_t'(LINE_BYTES);
  end

endmodule

`default_nettype wire

/* fetch/fetch_line_buffer.sv */
// fetch line buffer holding a four-slot ring of cache lines with a byte-granular read pointer
`timescale 1ns/1ps
`default_nettype none

module fetch_line_buffer
  import fetch_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       reset,
  input  wire logic       line_write,
  input  wire logic       flush,
  input  wire logic [3:0] start_offset,
  input  wire logic       consume,
  input  wire len_t       ir_len,
  icache_if.filler        cache,
  output logic            line_free,
  output logic            window_valid,
  output line_t           line_lo,
  output line_t           line_hi,
  output logic [3:0]      offset
);

  localparam int SLOT_W = $clog2(NUM_LINES);

  line_t                lines [NUM_LINES];
  logic [NUM_LINES-1:0] valid;
  logic [NUM_LINES-1:0] valid_next;
  logic [SLOT_W-1:0]    wr_slot;
  logic [SLOT_W-1:0]    next_slot;
  ptr_t                 rd_ptr;
  ptr_t                 rd_ptr_next;
  logic [4:0]           offset_sum;
  logic                 wrap;
  logic                 pair_valid;

  assign next_slot = rd_ptr.slot + SLOT_W'(1);

  // carry out of the byte offset means the current line is used up
  assign offset_sum = {1'b0, rd_ptr.offset} + {1'b0, ir_len};
  assign wrap       = consume & offset_sum[4];

  assign rd_ptr_next.slot   = rd_ptr.slot + SLOT_W'(offset_sum[4]);
  assign rd_ptr_next.offset = offset_sum[3:0];

  always_comb
  begin
    valid_next = valid;
    if (wrap)
      valid_next[rd_ptr.slot] = 1'b0;
    if (line_write)
      valid_next[wr_slot] = 1'b1;
  end

  // a window may span into the following line and needs both lines present
  assign pair_valid = valid[rd_ptr.slot] & valid[next_slot];

  assign line_free = ~&valid;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      valid        <= '0;
      wr_slot      <= '0;
      rd_ptr       <= '0;
      window_valid <= 1'b0;
    end
    else if (flush)
    begin
      valid         <= '0;
      wr_slot       <= '0;
      rd_ptr.slot   <= '0;
      rd_ptr.offset <= start_offset;
      window_valid  <= 1'b0;
    end
    else
    begin
      valid <= valid_next;
      if (line_write)
        wr_slot <= wr_slot + SLOT_W'(1);
      if (consume)
        rd_ptr <= rd_ptr_next;
      // moving to a new slot costs one bubble while the next pair is checked
      window_valid <= pair_valid & ~wrap;
    end
  end

  // line storage
  always_ff @(posedge clk)
  begin
    if (line_write)
      lines[wr_slot] <= cache.rsp_data;
  end

  assign line_lo = lines[rd_ptr.slot];
  assign line_hi = lines[next_slot];
  assign offset  = rd_ptr.offset;

endmodule

`default_nettype wire

/* hw/fetch_top.sv */
// fetch top level of the instruction fetch stage with cache port, line ring and window aligner
`timescale 1ns/1ps
`default_nettype none

module fetch_top
  import fetch_pkg::*;
#(
  parameter logic [15:0] RESET_CS = 16'hf000
) (
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire addr_t       eip,
  input  wire addr_t       jmp_target,
  input  wire addr_t       trap_target,
  input  wire logic [15:0] cs_in,
  input  wire addr_t       cs_limit,
  input  wire sel_t        redirect_sel,
  input  wire logic        load_eip,
  output logic             icache_req_valid,
  output addr_t            icache_req_addr,
  input  wire logic        icache_req_ready,
  input  wire logic        icache_rsp_valid,
  input  wire line_t       icache_rsp_data,
  output line_t            ir,
  output logic             ir_valid,
  output addr_t            ir_eip,
  output logic [15:0]      ir_cs,
  input  wire logic        ir_ready,
  input  wire len_t        ir_len,
  output logic             segment_limit_exception
);

  logic       line_write;
  logic       flush;
  logic [3:0] start_offset;
  logic       line_free;
  logic       window_valid;
  line_t      line_lo;
  line_t      line_hi;
  logic [3:0] offset;
  logic       consume;

  icache_if cache_bus ();

  assign icache_req_valid    = cache_bus.req_valid;
  assign icache_req_addr     = cache_bus.req_addr;
  assign cache_bus.req_ready = icache_req_ready;
  assign cache_bus.rsp_valid = icache_rsp_valid;
  assign cache_bus.rsp_data  = icache_rsp_data;

  // a pending limit violation hides the window from the decoder
  assign ir_valid = window_valid & ~segment_limit_exception;
  assign consume  = ir_valid & ir_ready;

  fetch_control #(
    .RESET_CS (RESET_CS)
  ) fetch_control_inst (
    .clk                     (clk),
    .reset                   (reset),
    .load_eip                (load_eip),
    .redirect_sel            (redirect_sel),
    .eip                     (eip),
    .jmp_target              (jmp_target),
    .trap_target             (trap_target),
    .cs_in                   (cs_in),
    .cs_limit                (cs_limit),
    .line_free               (line_free),
    .consume                 (consume),
    .ir_len                  (ir_len),
    .line_write              (line_write),
    .flush                   (flush),
    .start_offset            (start_offset),
    .ir_eip                  (ir_eip),
    .ir_cs                   (ir_cs),
    .segment_limit_exception (segment_limit_exception),
    .cache                   (cache_bus.requester)
  );

  fetch_line_buffer fetch_line_buffer_inst (
    .clk          (clk),
    .reset        (reset),
    .line_write   (line_write),
    .flush        (flush),
    .start_offset (start_offset),
    .consume      (consume),
    .ir_len       (ir_len),
    .cache        (cache_bus.filler),
    .line_free    (line_free),
    .window_valid (window_valid),
    .line_lo      (line_lo),
    .line_hi      (line_hi),
    .offset       (offset)
  );

  fetch_aligner fetch_aligner_inst (
    .line_lo (line_lo),
    .line_hi (line_hi),
    .offset  (offset),
    .ir      (ir)
  );

endmodule

`default_nettype wire

/* sim.f */
common/fetch_pkg.sv
common/icache_if.sv
fetch/fetch_control.sv
fetch/fetch_line_buffer.sv
fetch/fetch_aligner.sv
hw/fetch_top.sv
verification/clock_gen.sv
verification/fetch_tb.sv

/* verification/clock_gen.sv */
// clock and reset generator for the fetch testbench
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic reset
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // reset released on a rising edge after the hold cycles
  initial
  begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

/* verification/fetch_tb.sv */
// fetch testbench driving random cache and decoder traffic checked against a reference model
`timescale 1ns/1ps
`default_nettype none

module fetch_tb
  import fetch_pkg::*;
();

  localparam logic [15:0] RESET_CS = 16'hf000;

  logic        clk;
  logic        reset;
  addr_t       eip;
  addr_t       jmp_target;
  addr_t       trap_target;
  logic [15:0] cs_in;
  addr_t       cs_limit;
  sel_t        redirect_sel;
  logic        load_eip;
  logic        icache_req_valid;
  addr_t       icache_req_addr;
  logic        icache_req_ready;
  logic        icache_rsp_valid;
  line_t       icache_rsp_data;
  line_t       ir;
  logic        ir_valid;
  addr_t       ir_eip;
  logic [15:0] ir_cs;
  logic        ir_ready;
  len_t        ir_len;
  logic        segment_limit_exception;

  integer seed = 32'hafb9;
  int     errors = 0;
  int     tests = 0;
  int     windows = 0;
  int     ready_pct = 50;
  bit     timed_out = 1'b0;

  // cache responder state
  logic   pending;
  int     delay;
  addr_t  pend_addr;
  logic   prev_valid;
  logic   prev_ready;
  logic   prev_load;
  addr_t  prev_addr;

  // reference model state
  addr_t       exp_eip;
  logic [15:0] exp_cs;
  addr_t       exp_limit;
  logic        held_offer;

  clock_gen #(
    .PERIOD_NS    (10),
    .RESET_CYCLES (5)
  ) clock_gen_inst (
    .clk   (clk),
    .reset (reset)
  );

  fetch_top #(
    .RESET_CS (RESET_CS)
  ) fetch_top_inst (
    .clk                     (clk),
    .reset                   (reset),
    .eip                     (eip),
    .jmp_target              (jmp_target),
    .trap_target             (trap_target),
    .cs_in                   (cs_in),
    .cs_limit                (cs_limit),
    .redirect_sel            (redirect_sel),
    .load_eip                (load_eip),
    .icache_req_valid        (icache_req_valid),
    .icache_req_addr         (icache_req_addr),
    .icache_req_ready        (icache_req_ready),
    .icache_rsp_valid        (icache_rsp_valid),
    .icache_rsp_data         (icache_rsp_data),
    .ir                      (ir),
    .ir_valid                (ir_valid),
    .ir_eip                  (ir_eip),
    .ir_cs                   (ir_cs),
    .ir_ready                (ir_ready),
    .ir_len                  (ir_len),
    .segment_limit_exception (segment_limit_exception)
  );

  // memory byte is the low address byte folded with the upper bytes and xored with 5a
  function automatic logic [7:0] mem_byte(input addr_t a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
  endfunction

  function automatic line_t mem_window(input addr_t a);
    line_t w;
    for (int i = 0; i < LINE_BYTES; i++)
    begin
      w[i*8 +: 8] = mem_byte(a + addr_t'(i));
    end
    return w;
  endfunction

  function automatic logic over_limit(input addr_t start, input addr_t limit);
    return ({1'b0, start} + 33'd15) > {1'b0, limit};
  endfunction

  function automatic addr_t rand_target();
    return addr_t'({$random(seed)} & 32'h00ff_ffff);
  endfunction

  task automatic report_error(input string msg);
    $display("[ERROR] %0t %s", $time, msg);
    errors++;
  endtask

  // cache model with random ready that answers 1 to 6 cycles after acceptance
  always @(posedge clk)
  begin
    if (reset)
    begin
      icache_req_ready <= 1'b0;
      icache_rsp_valid <= 1'b0;
      pending          <= 1'b0;
      delay            <= 0;
      prev_valid       <= 1'b0;
      prev_load        <= 1'b0;
    end
    else
    begin
      if (icache_req_valid)
      begin
        if (icache_req_addr[3:0] != 4'h0)
          report_error($sformatf("request address %h is not line aligned", icache_req_addr));
        if (pending)
          report_error("request raised while another one is outstanding");
        if (icache_req_addr > exp_limit)
          report_error($sformatf("request %h beyond limit %h", icache_req_addr, exp_limit));
      end
      // a held request may only move when a redirect abandons it
      if (prev_valid && !prev_ready && !prev_load)
      begin
        if (!icache_req_valid || icache_req_addr != prev_addr)
          report_error($sformatf("held request %h dropped or changed", prev_addr));
      end
      prev_valid       <= icache_req_valid;
      prev_ready       <= icache_req_ready;
      prev_addr        <= icache_req_addr;
      prev_load        <= load_eip;
      icache_req_ready <= ({$random(seed)} % 2) == 1;
      icache_rsp_valid <= 1'b0;
      if (icache_req_valid && icache_req_ready)
      begin
        pending   <= 1'b1;
        delay     <= 1 + {$random(seed)} % 6;
        pend_addr <= icache_req_addr;
      end
      else if (pending)
      begin
        if (delay <= 1)
        begin
          icache_rsp_valid <= 1'b1;
          icache_rsp_data  <= mem_window(pend_addr);
          pending          <= 1'b0;
        end
        else
          delay <= delay - 1;
      end
    end
  end

  // decoder model
  always @(posedge clk)
  begin
    if (reset)
    begin
      ir_ready <= 1'b0;
      ir_len   <= 4'd1;
    end
    else
    begin
      ir_ready <= ({$random(seed)} % 100) < ready_pct;
      ir_len   <= len_t'(1 + {$random(seed)} % 15);
    end
  end

  // reference model of eip, cs and the limit check
  always @(posedge clk)
  begin
    if (reset)
    begin
      exp_eip    <= '0;
      exp_cs     <= RESET_CS;
      exp_limit  <= 32'hffff_ffff;
      held_offer <= 1'b0;
    end
    else
    begin
      if (ir_eip != exp_eip)
        report_error($sformatf("ir_eip %h, expected %h", ir_eip, exp_eip));
      if (ir_cs != exp_cs)
        report_error($sformatf("ir_cs %h, expected %h", ir_cs, exp_cs));
      if (segment_limit_exception != over_limit(exp_eip, exp_limit))
        report_error($sformatf("exception %b at eip %h limit %h", segment_limit_exception,
                               exp_eip, exp_limit));
      if (ir_valid && over_limit(exp_eip, exp_limit))
        report_error($sformatf("window at %h offered past limit %h", exp_eip, exp_limit));
      if (ir_valid && ir != mem_window(exp_eip))
        report_error($sformatf("ir %h, expected %h", ir, mem_window(exp_eip)));
      // an offered window stays until it is taken or a redirect replaces it
      if (held_offer && !ir_valid)
        report_error($sformatf("window at %h withdrawn while not taken", exp_eip));
      held_offer <= ir_valid && !ir_ready && !load_eip;
      if (load_eip)
      begin
        case (redirect_sel)
          sel_jump: exp_eip <= jmp_target;
          sel_trap: exp_eip <= trap_target;
          default:  exp_eip <= eip;
        endcase
        exp_cs    <= cs_in;
        exp_limit <= cs_limit;
      end
      else if (ir_valid && ir_ready)
      begin
        exp_eip <= exp_eip + addr_t'(ir_len);
        windows <= windows + 1;
      end
    end
  end

  task automatic end_run();
    $display("tests %0d, windows %0d, errors %0d", tests, windows, errors);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  endtask

  // called right after a rising edge and holds load_eip for one cycle
  task automatic redirect(input sel_t sel, input addr_t target, input addr_t limit);
    eip          <= (sel == sel_eip) ? target : rand_target();
    jmp_target   <= (sel == sel_jump) ? target : rand_target();
    trap_target  <= (sel == sel_trap) ? target : rand_target();
    cs_in        <= 16'($random(seed));
    cs_limit     <= limit;
    redirect_sel <= sel;
    load_eip     <= 1'b1;
    @(posedge clk);
    load_eip <= 1'b0;
  endtask

  task automatic wait_windows(input int count, input int max_cycles);
    int goal;
    int cycles;
    goal = windows + count;
    cycles = 0;
    while (!timed_out && windows < goal && cycles < max_cycles)
    begin
      @(posedge clk);
      cycles++;
    end
    if (!timed_out && windows < goal)
    begin
      $display("timeout: %0d windows were still missing", goal - windows);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  // waits for an outstanding cache request or for the limit exception
  task automatic wait_until_seen(input bit exception, input int max_cycles);
    int cycles;
    cycles = 0;
    while (!timed_out && !(exception ? segment_limit_exception : pending)
           && cycles < max_cycles)
    begin
      @(posedge clk);
      cycles++;
    end
    if (!timed_out && !(exception ? segment_limit_exception : pending))
    begin
      $display("timeout: no %s appeared", exception ? "limit exception" : "cache request");
      errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic finish_test(input string name, input int w0, input int e0);
    tests++;
    $display("%s: %0d windows, %0d errors", name, windows - w0, errors - e0);
  endtask

  initial
  begin : stimulus
    int    w0;
    int    e0;
    int    cycles;
    addr_t base;
    addr_t start;
    addr_t limit;
    eip              = '0;
    jmp_target       = '0;
    trap_target      = '0;
    cs_in            = '0;
    cs_limit         = 32'hffff_ffff;
    redirect_sel     = sel_eip;
    load_eip         = 1'b0;
    icache_req_ready = 1'b0;
    icache_rsp_valid = 1'b0;
    icache_rsp_data  = '0;
    ir_ready         = 1'b0;
    ir_len           = 4'd1;
    cycles = 0;
    do
    begin
      @(posedge clk);
      cycles++;
    end while (reset && cycles < 20);
    if (reset)
    begin
      $display("timeout: reset was never released");
      errors++;
      timed_out = 1'b1;
    end

    w0 = windows;
    e0 = errors;
    ready_pct = 70;
    redirect(sel_eip, rand_target(), 32'hffff_ffff);
    wait_windows(60, 4000);
    finish_test("eip redirect", w0, e0);

    // slow decoder keeps the window under back-pressure
    w0 = windows;
    e0 = errors;
    ready_pct = 25;
    redirect(sel_eip, rand_target(), 32'hffff_ffff);
    wait_windows(60, 8000);
    finish_test("lengths under back-pressure", w0, e0);

    w0 = windows;
    e0 = errors;
    ready_pct = 60;
    for (int i = 0; i < 8; i++)
    begin
      wait_until_seen(1'b0, 200);
      redirect((({$random(seed)} % 2) == 1) ? sel_jump : sel_trap, rand_target(),
               32'hffff_ffff);
      wait_windows(6, 1000);
    end
    finish_test("jump and trap redirects", w0, e0);

    // limit a few lines above the start and never on the last byte of a line
    w0 = windows;
    e0 = errors;
    base  = rand_target() & 32'hffff_fff0;
    start = base + addr_t'({$random(seed)} % 16);
    limit = base + addr_t'(48 + 16 * ({$random(seed)} % 4) + {$random(seed)} % 15);
    redirect(sel_eip, start, limit);
    wait_until_seen(1'b1, 2000);
    repeat (20) @(posedge clk);
    redirect(sel_jump, rand_target(), 32'hffff_ffff);
    wait_windows(20, 2000);
    finish_test("segment limit", w0, e0);

    end_run();
  end

endmodule

`default_nettype wire
